//--- hdl/posit_pkg.sv
`default_nettype none

package posit_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned WIDTH        = 16;
  localparam int unsigned TAG_W        = 4;
  localparam int unsigned NUM_OPGROUPS = 2;

  // --------------------------------------------------
  // Opcodes and groups
  // --------------------------------------------------
  typedef enum logic [2:0] {
    OP_MIN,
    OP_MAX,
    OP_EQ,
    OP_LT,
    OP_LE,
    OP_NEG,
    OP_P2I,
    OP_I2P
  } operation_e;

  typedef enum logic [0:0] {
    GRP_NONCOMP,
    GRP_CONV
  } opgroup_e;

  // Invalid and inexact flags
  typedef struct packed {
    logic nv;
    logic nx;
  } status_t;

  // Posit16 word, sign plus body
  typedef struct packed {
    logic        sign;
    logic [14:0] body;
  } posit_bits_t;

  // Same word seen as a posit or as a signed integer
  typedef union packed {
    posit_bits_t              posit;
    logic signed [WIDTH-1:0]  int_val;
  } operand_u;

  typedef struct packed {
    operand_u         opa;
    operand_u         opb;
    operation_e       op;
    logic [TAG_W-1:0] tag;
  } request_t;

  typedef struct packed {
    logic [WIDTH-1:0] result;
    status_t          status;
    logic [TAG_W-1:0] tag;
  } result_t;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic opgroup_e get_opgroup(input operation_e op);
    case (op)
      OP_P2I, OP_I2P: return GRP_CONV;
      default:        return GRP_NONCOMP;
    endcase
  endfunction

  // NaR is the sign bit alone
  function automatic logic is_nar(input operand_u op);
    return op.posit.sign && (op.posit.body == '0);
  endfunction

endpackage

`default_nettype wire

//--- hdl/posit_noncomp.sv
`timescale 1ns/100ps
`default_nettype none

module posit_noncomp (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               flush_i,
  input  wire logic               in_valid_i,
  input  posit_pkg::request_t     req_i,
  input  wire logic               out_ready_i,
  output logic                    in_ready_o,
  output logic                    out_valid_o,
  output posit_pkg::result_t      res_o,
  output logic                    busy_o
);

  posit_pkg::operand_u a;
  posit_pkg::operand_u b;
  posit_pkg::result_t  res_d;
  posit_pkg::result_t  res_q;
  logic                valid_q;
  logic                a_lt_b;
  logic                a_eq_b;

  assign a = req_i.opa;
  assign b = req_i.opb;

  // Signed integer order puts NaR below every number
  assign a_lt_b = a.int_val < b.int_val;
  assign a_eq_b = a.int_val == b.int_val;

  always_comb begin
    res_d        = '0;
    res_d.tag    = req_i.tag;
    res_d.status = '0;
    case (req_i.op)
      posit_pkg::OP_MIN: res_d.result = (b.int_val < a.int_val) ? b : a;
      posit_pkg::OP_MAX: res_d.result = a_lt_b ? b : a;
      posit_pkg::OP_EQ:  res_d.result = {15'd0, a_eq_b};
      posit_pkg::OP_LT:  res_d.result = {15'd0, a_lt_b};
      posit_pkg::OP_LE:  res_d.result = {15'd0, a_lt_b | a_eq_b};
      posit_pkg::OP_NEG: begin
        // Zero and NaR have an empty body and map to themselves
        if (a.posit.body == '0) begin
          res_d.result = a;
        end else begin
          res_d.result = {~a.posit.sign, ~a.posit.body} + 16'd1;
        end
      end
      default:           res_d.result = a;
    endcase
  end

  // Output register, holds until granted
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      res_q <= res_d;
    end
  end

  assign out_valid_o = valid_q;
  assign res_o       = res_q;
  assign busy_o      = valid_q;

endmodule

`default_nettype wire

//--- hdl/posit_conv.sv
`timescale 1ns/100ps
`default_nettype none

module posit_conv (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               flush_i,
  input  wire logic               in_valid_i,
  input  posit_pkg::request_t     req_i,
  input  wire logic               out_ready_i,
  output logic                    in_ready_o,
  output logic                    out_valid_o,
  output posit_pkg::result_t      res_o,
  output logic                    busy_o
);

  // Normalized value: (-1)^sign * 1.sig[14:0] * 2^scale
  typedef struct packed {
    logic                          to_int;
    logic                          sign;
    logic                          zero;
    logic                          nar;
    logic signed [6:0]             scale;
    logic [15:0]                   sig;
    logic [posit_pkg::TAG_W-1:0]   tag;
  } decoded_t;

  posit_pkg::operand_u a;
  decoded_t            dec_d;
  decoded_t            dec_q;
  posit_pkg::result_t  enc_d;
  posit_pkg::result_t  enc_q;
  logic                s1_valid_q;
  logic                s2_valid_q;
  logic                s1_ready;
  logic                s2_ready;

  assign a = req_i.opa;

  // --------------------------------------------------
  // Stage one, decode
  // --------------------------------------------------
  always_comb begin : decode
    logic [15:0]       mag;
    logic [14:0]       body;
    logic [14:0]       tail;
    logic [3:0]        run_len;
    logic              run;
    logic signed [6:0] run_s;
    logic signed [6:0] regime;
    logic [3:0]        lead;
    dec_d        = '0;
    dec_d.tag    = req_i.tag;
    dec_d.to_int = (req_i.op == posit_pkg::OP_P2I);
    dec_d.zero   = (a.int_val == 0);
    run_len      = '0;
    run          = 1'b1;
    lead         = '0;
    if (dec_d.to_int) begin
      dec_d.sign = a.posit.sign;
      dec_d.nar  = posit_pkg::is_nar(a);
      mag        = a.posit.sign ? -a.int_val : a.int_val;
      body       = mag[14:0];
      // Regime run length
      for (int i = 14; i >= 0; i--) begin
        if (run && (body[i] == body[14])) begin
          run_len = run_len + 4'd1;
        end else begin
          run = 1'b0;
        end
      end
      // Drop regime and terminator, exponent is left at the top
      tail        = body << ({1'b0, run_len} + 5'd1);
      run_s       = 7'(run_len);
      regime      = body[14] ? run_s - 7'sd1 : -run_s;
      dec_d.scale = {regime[5:0], tail[14]};
      dec_d.sig   = {1'b1, tail[13:0], 1'b0};
    end else begin
      dec_d.sign = a.int_val < 0;
      mag        = dec_d.sign ? -a.int_val : a.int_val;
      body       = mag[14:0];
      tail       = body;
      run_s      = '0;
      regime     = '0;
      for (int i = 0; i < 16; i++) begin
        if (mag[i]) begin
          lead = 4'(i);
        end
      end
      dec_d.scale = 7'(lead);
      dec_d.sig   = mag << (4'd15 - lead);
    end
  end

  // --------------------------------------------------
  // Stage two, round and encode
  // --------------------------------------------------
  always_comb begin : round_encode
    logic [31:0] ext;
    logic [5:0]  shamt;
    logic [3:0]  rshift;
    logic [16:0] mag_r;
    logic [14:0] body_r;
    logic        guard;
    logic        sticky;
    logic        ovf;
    enc_d     = '0;
    enc_d.tag = dec_q.tag;
    shamt     = '0;
    rshift    = '0;
    mag_r     = '0;
    body_r    = '0;
    ovf       = 1'b0;
    if (dec_q.to_int) begin
      if (dec_q.scale > 7'sd15) begin
        shamt = '0;
      end else if (dec_q.scale < -7'sd2) begin
        shamt = 6'd17;
      end else begin
        shamt = 6'(7'sd15 - dec_q.scale);
      end
      ext    = {dec_q.sig, 16'd0} >> shamt;
      guard  = ext[15];
      sticky = |ext[14:0];
      mag_r  = {1'b0, ext[31:16]} + 17'(guard & (sticky | ext[16]));
      ovf    = (dec_q.scale > 7'sd15) ||
               (dec_q.sign ? (mag_r > 17'd32768) : (mag_r > 17'd32767));
      if (dec_q.nar) begin
        enc_d.result    = 16'h8000;
        enc_d.status.nv = 1'b1;
      end else if (dec_q.zero) begin
        enc_d.result = '0;
      end else if (ovf) begin
        enc_d.result    = dec_q.sign ? 16'h8000 : 16'h7fff;
        enc_d.status.nx = 1'b1;
      end else begin
        enc_d.result    = dec_q.sign ? -mag_r[15:0] : mag_r[15:0];
        enc_d.status.nx = guard | sticky;
      end
    end else begin
      // Regime of r+1 ones and a zero, then exponent and fraction
      rshift = {1'b0, dec_q.scale[3:1]} + 4'd1;
      ext    = {1'b0, dec_q.scale[0], dec_q.sig[14:0], 15'd0};
      ext    = (ext >> rshift) | ~(32'hffff_ffff >> rshift);
      guard  = ext[16];
      sticky = |ext[15:0];
      body_r = ext[31:17] + 15'(guard & (sticky | ext[17]));
      if (dec_q.zero) begin
        enc_d.result = '0;
      end else begin
        enc_d.result    = dec_q.sign ? -{1'b0, body_r} : {1'b0, body_r};
        enc_d.status.nx = guard | sticky;
      end
    end
  end

  // --------------------------------------------------
  // Pipeline control
  // --------------------------------------------------
  assign s2_ready   = ~s2_valid_q | out_ready_i;
  assign s1_ready   = ~s1_valid_q | s2_ready;
  assign in_ready_o = s1_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= in_valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && s1_ready) begin
      dec_q <= dec_d;
    end
    if (s1_valid_q && s2_ready) begin
      enc_q <= enc_d;
    end
  end

  assign out_valid_o = s2_valid_q;
  assign res_o       = enc_q;
  assign busy_o      = s1_valid_q | s2_valid_q;

endmodule

`default_nettype wire

//--- hdl/posit_result_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module posit_result_arbiter (
  input  wire logic                                        clk_i,
  input  wire logic                                        rst_n_i,
  input  wire logic                                        flush_i,
  input  wire logic [posit_pkg::NUM_OPGROUPS-1:0]          valid_i,
  input  posit_pkg::result_t [posit_pkg::NUM_OPGROUPS-1:0] res_i,
  input  wire logic                                        full_i,
  output logic [posit_pkg::NUM_OPGROUPS-1:0]               grant_o,
  output logic                                             push_o,
  output posit_pkg::result_t                               res_o
);

  localparam int unsigned NumGroups = posit_pkg::NUM_OPGROUPS;
  localparam int unsigned PtrW      = (NumGroups > 1) ? $clog2(NumGroups) : 1;

  logic [PtrW-1:0] ptr_q;
  logic [PtrW-1:0] sel;
  logic            any_valid;

  // First valid group at or after the pointer
  always_comb begin
    int unsigned idx;
    sel       = '0;
    any_valid = 1'b0;
    for (int unsigned i = 0; i < NumGroups; i++) begin
      idx = (int'(ptr_q) + i) % NumGroups;
      if (!any_valid && valid_i[idx]) begin
        any_valid = 1'b1;
        sel       = PtrW'(idx);
      end
    end
  end

  assign push_o = any_valid & ~full_i;

  always_comb begin
    grant_o = '0;
    if (push_o) begin
      grant_o[sel] = 1'b1;
    end
  end

  assign res_o = res_i[sel];

  // Next search starts after the winner
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      ptr_q <= '0;
    end else if (push_o) begin
      ptr_q <= PtrW'((int'(sel) + 1) % NumGroups);
    end
  end

endmodule

`default_nettype wire

//--- hdl/posit_result_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module posit_result_fifo #(
  parameter int unsigned FifoDepth = 4
) (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               flush_i,
  input  wire logic               push_i,
  input  posit_pkg::result_t      res_i,
  input  wire logic               out_ready_i,
  output logic                    full_o,
  output logic                    out_valid_o,
  output posit_pkg::result_t      res_o,
  output logic                    busy_o
);

  localparam int unsigned AddrW = $clog2(FifoDepth);

  posit_pkg::result_t mem [FifoDepth];
  logic [AddrW-1:0]   wr_ptr_q;
  logic [AddrW-1:0]   rd_ptr_q;
  logic [AddrW:0]     count_q;
  logic               pop;

  assign full_o      = (count_q == (AddrW + 1)'(FifoDepth));
  assign out_valid_o = (count_q != '0);
  assign pop         = out_valid_o & out_ready_i;

  // Pointers wrap on their own for a power-of-two depth
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (AddrW + 1)'(push_i) - (AddrW + 1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= res_i;
    end
  end

  assign res_o  = mem[rd_ptr_q];
  assign busy_o = out_valid_o;

endmodule

`default_nettype wire

//--- hdl/posit_top.sv
`timescale 1ns/100ps
`default_nettype none

module posit_top #(
  parameter int unsigned FifoDepth = 4
) (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               flush_i,
  input  posit_pkg::request_t     req_i,
  input  wire logic               in_valid_i,
  input  wire logic               out_ready_i,
  output logic                    in_ready_o,
  output posit_pkg::result_t      res_o,
  output logic                    out_valid_o,
  output logic                    busy_o
);

  localparam int unsigned NumGroups = posit_pkg::NUM_OPGROUPS;

  posit_pkg::opgroup_e                 sel_grp;
  logic [NumGroups-1:0]                grp_in_valid;
  logic [NumGroups-1:0]                grp_in_ready;
  logic [NumGroups-1:0]                grp_out_valid;
  logic [NumGroups-1:0]                grp_grant;
  logic [NumGroups-1:0]                grp_busy;
  posit_pkg::result_t [NumGroups-1:0]  grp_res;
  posit_pkg::result_t                  arb_res;
  logic                                arb_push;
  logic                                fifo_full;
  logic                                fifo_busy;

  // --------------------------------------------------
  // Dispatch
  // --------------------------------------------------
  assign sel_grp    = posit_pkg::get_opgroup(req_i.op);
  assign in_ready_o = in_valid_i & grp_in_ready[sel_grp];

  for (genvar g = 0; g < NumGroups; g++) begin : gen_in_valid
    assign grp_in_valid[g] = in_valid_i & (sel_grp == posit_pkg::opgroup_e'(g));
  end

  posit_noncomp i_noncomp (
    .clk_i,
    .rst_n_i,
    .flush_i,
    .in_valid_i  (grp_in_valid[posit_pkg::GRP_NONCOMP]),
    .req_i,
    .out_ready_i (grp_grant[posit_pkg::GRP_NONCOMP]),
    .in_ready_o  (grp_in_ready[posit_pkg::GRP_NONCOMP]),
    .out_valid_o (grp_out_valid[posit_pkg::GRP_NONCOMP]),
    .res_o       (grp_res[posit_pkg::GRP_NONCOMP]),
    .busy_o      (grp_busy[posit_pkg::GRP_NONCOMP])
  );

  posit_conv i_conv (
    .clk_i,
    .rst_n_i,
    .flush_i,
    .in_valid_i  (grp_in_valid[posit_pkg::GRP_CONV]),
    .req_i,
    .out_ready_i (grp_grant[posit_pkg::GRP_CONV]),
    .in_ready_o  (grp_in_ready[posit_pkg::GRP_CONV]),
    .out_valid_o (grp_out_valid[posit_pkg::GRP_CONV]),
    .res_o       (grp_res[posit_pkg::GRP_CONV]),
    .busy_o      (grp_busy[posit_pkg::GRP_CONV])
  );

  // --------------------------------------------------
  // Arbitration and result queue
  // --------------------------------------------------
  posit_result_arbiter i_arbiter (
    .clk_i,
    .rst_n_i,
    .flush_i,
    .valid_i (grp_out_valid),
    .res_i   (grp_res),
    .full_i  (fifo_full),
    .grant_o (grp_grant),
    .push_o  (arb_push),
    .res_o   (arb_res)
  );

  posit_result_fifo #(
    .FifoDepth (FifoDepth)
  ) i_fifo (
    .clk_i,
    .rst_n_i,
    .flush_i,
    .push_i      (arb_push),
    .res_i       (arb_res),
    .out_ready_i,
    .full_o      (fifo_full),
    .out_valid_o,
    .res_o,
    .busy_o      (fifo_busy)
  );

  assign busy_o = (|grp_busy) | fifo_busy;

endmodule

`default_nettype wire

//--- testbench/posit_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module posit_clk_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/posit_properties.sv
`timescale 1ns/100ps
`default_nettype none

module posit_properties (
  input wire logic           clk_i,
  input wire logic           rst_n_i,
  input wire logic           flush_i,
  input wire logic           out_ready_i,
  input wire logic           out_valid_o,
  input wire logic           busy_o,
  input posit_pkg::result_t  res_o
);

  // Failed assertions so far
  int unsigned fail_cnt;

  initial begin
    fail_cnt = 0;
  end

  // Reset and flush empty the result queue
  reset_clears_valid: assert property (
    @(posedge clk_i) (!rst_n_i || flush_i) |=> !out_valid_o
  ) else begin
    fail_cnt++;
    $error("out_valid_o high after a reset or flush cycle");
  end

  // --------------------------------------------------
  // Output handshake
  // --------------------------------------------------
  stalled_result_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> $stable(res_o)
  ) else begin
    fail_cnt++;
    $error("res_o changed while stalled by out_ready_i");
  end

  // Any queued result keeps the unit busy
  valid_implies_busy: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o |-> busy_o
  ) else begin
    fail_cnt++;
    $error("out_valid_o high while busy_o low");
  end

endmodule

`default_nettype wire

//--- testbench/posit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module posit_tb;

  localparam int unsigned FifoDepth  = 4;
  localparam int unsigned NumTags    = 1 << posit_pkg::TAG_W;
  localparam int unsigned NumVecs    = 28;
  localparam int unsigned FlushReqs  = 4;
  localparam int unsigned NumReqs    = 2 * NumVecs + 2 * FlushReqs;
  localparam int unsigned TimeoutCyc = NumReqs * 20;
  localparam int unsigned Seed       = 6;

  typedef struct packed {
    posit_pkg::operation_e op;
    logic [15:0]           opa;
    logic [15:0]           opb;
    logic [15:0]           res;
    posit_pkg::status_t    status;
  } vector_t;

  // op, opa, opb, expected result, expected {nv, nx}
  localparam vector_t Vectors [NumVecs] = '{
    '{posit_pkg::OP_MIN, 16'h4000, 16'hc000, 16'hc000, 2'b00},
    '{posit_pkg::OP_MAX, 16'h4000, 16'hc000, 16'h4000, 2'b00},
    '{posit_pkg::OP_MIN, 16'h8000, 16'h4000, 16'h8000, 2'b00},
    '{posit_pkg::OP_MAX, 16'h8000, 16'hc000, 16'hc000, 2'b00},
    '{posit_pkg::OP_MIN, 16'h5000, 16'h5000, 16'h5000, 2'b00},
    '{posit_pkg::OP_EQ,  16'h5000, 16'h5000, 16'h0001, 2'b00},
    '{posit_pkg::OP_EQ,  16'h5000, 16'h4000, 16'h0000, 2'b00},
    '{posit_pkg::OP_LT,  16'h8000, 16'hffff, 16'h0001, 2'b00},
    '{posit_pkg::OP_LT,  16'h4000, 16'h4000, 16'h0000, 2'b00},
    '{posit_pkg::OP_LE,  16'h4000, 16'h4000, 16'h0001, 2'b00},
    '{posit_pkg::OP_LE,  16'h4000, 16'hc000, 16'h0000, 2'b00},
    '{posit_pkg::OP_NEG, 16'h4000, 16'h0000, 16'hc000, 2'b00},
    '{posit_pkg::OP_NEG, 16'hc000, 16'h0000, 16'h4000, 2'b00},
    '{posit_pkg::OP_NEG, 16'h0000, 16'h0000, 16'h0000, 2'b00},
    '{posit_pkg::OP_NEG, 16'h8000, 16'h0000, 16'h8000, 2'b00},
    // Posit to int, ties go to the even integer
    '{posit_pkg::OP_P2I, 16'h4000, 16'h0000, 16'h0001, 2'b00},
    '{posit_pkg::OP_P2I, 16'h5400, 16'h0000, 16'h0002, 2'b01},
    '{posit_pkg::OP_P2I, 16'h4800, 16'h0000, 16'h0002, 2'b01},
    '{posit_pkg::OP_P2I, 16'hac00, 16'h0000, 16'hfffe, 2'b01},
    '{posit_pkg::OP_P2I, 16'h7fff, 16'h0000, 16'h7fff, 2'b01},
    '{posit_pkg::OP_P2I, 16'h8000, 16'h0000, 16'h8000, 2'b10},
    '{posit_pkg::OP_P2I, 16'h7df4, 16'h0000, 16'h03e8, 2'b00},
    // Int to posit
    '{posit_pkg::OP_I2P, 16'h0001, 16'h0000, 16'h4000, 2'b00},
    '{posit_pkg::OP_I2P, 16'hffff, 16'h0000, 16'hc000, 2'b00},
    '{posit_pkg::OP_I2P, 16'h03e8, 16'h0000, 16'h7df4, 2'b00},
    '{posit_pkg::OP_I2P, 16'h2710, 16'h0000, 16'h7f4e, 2'b01},
    '{posit_pkg::OP_I2P, 16'h7fff, 16'h0000, 16'h7fa0, 2'b01},
    '{posit_pkg::OP_I2P, 16'h8000, 16'h0000, 16'h8060, 2'b00}
  };

  logic                clk;
  logic                rst_n;
  logic                flush;
  posit_pkg::request_t req;
  logic                in_valid;
  logic                in_ready;
  logic                out_valid;
  logic                out_ready;
  posit_pkg::result_t  res_out;
  logic                busy;

  // Scoreboard, indexed by tag
  logic [15:0]         exp_res [NumTags];
  posit_pkg::status_t  exp_status [NumTags];
  int unsigned         sent_cnt [NumTags];
  int unsigned         ret_cnt [NumTags];
  logic [posit_pkg::TAG_W-1:0] next_tag;
  logic                hold_ready;
  int unsigned         issued;
  int unsigned         received;
  int unsigned         flushed;
  int unsigned         mismatch_errs;
  int unsigned         stray_errs;
  int unsigned         flow_errs;
  int unsigned         prop_errs;

  posit_clk_gen #(
    .PeriodNs    (40),
    .ResetCycles (5)
  ) clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  posit_top #(
    .FifoDepth (FifoDepth)
  ) dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .req_i       (req),
    .in_valid_i  (in_valid),
    .out_ready_i (out_ready),
    .in_ready_o  (in_ready),
    .res_o       (res_out),
    .out_valid_o (out_valid),
    .busy_o      (busy)
  );

  bind posit_top posit_properties props_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .busy_o      (busy_o),
    .res_o       (res_o)
  );

  function automatic int unsigned outstanding();
    int unsigned n;
    n = 0;
    for (int t = 0; t < NumTags; t++) begin
      if (sent_cnt[t] != ret_cnt[t]) begin
        n++;
      end
    end
    return n;
  endfunction

  // --------------------------------------------------
  // Request side, entered and left on a falling edge
  // --------------------------------------------------
  task automatic send_request(input vector_t vec);
    logic accepted;
    accepted = 1'b0;
    while (sent_cnt[next_tag] != ret_cnt[next_tag]) begin
      @(negedge clk);
    end
    req.opa  = vec.opa;
    req.opb  = vec.opb;
    req.op   = vec.op;
    req.tag  = next_tag;
    in_valid = 1'b1;
    while (!accepted) begin
      #1;
      if (in_ready) begin
        accepted            = 1'b1;
        exp_res[next_tag]    = vec.res;
        exp_status[next_tag] = vec.status;
        sent_cnt[next_tag]   = sent_cnt[next_tag] + 1;
        issued++;
      end
      @(negedge clk);
    end
    in_valid = 1'b0;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic check_idle(input string where);
    #1;
    assert (!busy && !out_valid) else begin
      $display("mismatch busy_o, out_valid_o %s: got 0x%h, 0x%h expected 0x0, 0x0",
               where, busy, out_valid);
      flow_errs++;
    end
    // Probe ready without letting a posedge take the request
    in_valid = 1'b1;
    #1;
    assert (in_ready) else begin
      $display("mismatch in_ready_o %s: got 0x%h expected 0x1", where, in_ready);
      flow_errs++;
    end
    in_valid = 1'b0;
  endtask

  task automatic flush_midstream();
    hold_ready = 1'b1;
    @(negedge clk);
    for (int i = 0; i < FlushReqs; i++) begin
      send_request(Vectors[$urandom % NumVecs]);
    end
    repeat (2) @(negedge clk);
    flush   = 1'b1;
    flushed = flushed + outstanding();
    for (int t = 0; t < NumTags; t++) begin
      sent_cnt[t] = ret_cnt[t];
    end
    @(negedge clk);
    flush = 1'b0;
    check_idle("after flush");
    hold_ready = 1'b0;
  endtask

  task automatic wait_drain();
    while (outstanding() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  // --------------------------------------------------
  // Output side
  // --------------------------------------------------
  task automatic check_result(input posit_pkg::result_t got);
    assert (sent_cnt[got.tag] != ret_cnt[got.tag]) else begin
      $display("result with tag 0x%h arrived with no request outstanding", got.tag);
      stray_errs++;
    end
    if (sent_cnt[got.tag] != ret_cnt[got.tag]) begin
      assert (got.result == exp_res[got.tag]) else begin
        $display("mismatch res_o.result tag 0x%h: got 0x%04h expected 0x%04h",
                 got.tag, got.result, exp_res[got.tag]);
        mismatch_errs++;
      end
      assert (got.status == exp_status[got.tag]) else begin
        $display("mismatch res_o.status tag 0x%h: got 0x%h expected 0x%h",
                 got.tag, got.status, exp_status[got.tag]);
        mismatch_errs++;
      end
      ret_cnt[got.tag] = ret_cnt[got.tag] + 1;
      received++;
    end
  endtask

  // Pop decision is stable between the falling edge and the next rising edge
  initial begin
    forever begin
      @(negedge clk);
      #2;
      if (rst_n && !flush && out_valid && out_ready) begin
        check_result(res_out);
      end
    end
  end

  initial begin
    out_ready = 1'b0;
    forever begin
      @(negedge clk);
      out_ready = hold_ready ? 1'b0 : (($urandom % 4) != 0);
    end
  end

  initial begin
    repeat (TimeoutCyc) @(posedge clk);
    $display("timeout after %0d cycles with %0d results outstanding",
             TimeoutCyc, outstanding());
    $display("SIMULATION FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(Seed));
    flush         = 1'b0;
    in_valid      = 1'b0;
    req           = '0;
    hold_ready    = 1'b0;
    next_tag      = '0;
    issued        = 0;
    received      = 0;
    flushed       = 0;
    mismatch_errs = 0;
    stray_errs    = 0;
    flow_errs     = 0;
    prop_errs     = 0;
    for (int t = 0; t < NumTags; t++) begin
      sent_cnt[t] = 0;
      ret_cnt[t]  = 0;
    end
    @(posedge rst_n);
    @(negedge clk);
    check_idle("after reset");
    @(negedge clk);
    for (int i = 0; i < NumVecs; i++) begin
      send_request(Vectors[i]);
    end
    // Random order mixes both groups under back-pressure
    for (int i = 0; i < NumVecs; i++) begin
      send_request(Vectors[$urandom % NumVecs]);
    end
    wait_drain();
    flush_midstream();
    for (int i = 0; i < FlushReqs; i++) begin
      send_request(Vectors[$urandom % NumVecs]);
    end
    wait_drain();
    check_idle("after drain");
    assert (issued == received + flushed) else begin
      $display("result count off: %0d issued, %0d returned, %0d flushed",
               issued, received, flushed);
      flow_errs++;
    end
    prop_errs = dut_i.props_i.fail_cnt;
    $display("errors: %0d mismatches, %0d stray results, %0d other failures, %0d %s",
             mismatch_errs, stray_errs, flow_errs, prop_errs, "assertion failures");
    if (mismatch_errs == 0 && stray_errs == 0 && flow_errs == 0 && prop_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hdl/posit_pkg.sv
hdl/posit_noncomp.sv
hdl/posit_conv.sv
hdl/posit_result_arbiter.sv
hdl/posit_result_fifo.sv
hdl/posit_top.sv
testbench/posit_clk_gen.sv
testbench/posit_properties.sv
testbench/posit_tb.sv

//--- Makefile
# Verilator simulation of the posit16 processing unit

VERILATOR ?= verilator
TOP       ?= posit_tb
FILELIST  ?= sources.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build and run $(TOP), fail if $(LOG) reports a failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
